// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fpu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+.
fp_format_pkg.sv
fpu_op_pkg.sv
fp_unpack.sv
fp_align_add.sv
fp_normalize.sv
fp_round_pack.sv
fpu_pipe.sv
tb_clock_gen.sv
fpu_tb.sv

// ==== fp_align_add.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_align_add (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    unp_valid,
    input  fpu_op_pkg::fpu_op_t     unp_op,
    input  fpu_op_pkg::round_mode_t unp_rm,
    input  logic                    a_sign,
    input  logic                    b_sign,
    input  fp_format_pkg::iexp_t    a_exp,
    input  fp_format_pkg::iexp_t    b_exp,
    input  fp_format_pkg::mant_t    a_mant,
    input  fp_format_pkg::mant_t    b_mant,
    input  logic                    a_nan,
    input  logic                    b_nan,
    input  logic                    a_inf,
    input  logic                    b_inf,
    input  logic                    a_zero,
    input  logic                    b_zero,
    input  logic                    snan,
    output logic                    valid,
    output fpu_op_pkg::round_mode_t rm_q,
    output logic                    sign,
    output fp_format_pkg::iexp_t    exp,
    output fp_format_pkg::mant_t    mant,
    output logic                    bypass,
    output fp_format_pkg::fp32_t    bypass_word,
    output logic                    nv
);
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    logic  b_eff, eff_sub, a_big, mag_eq, both_zero, any_nan, lt, eq, pick_a;
    logic  res_sign, byp, nv_d;
    iexp_t big_exp, diff;
    mant_t big_mant, small_mant, small_sh, sum;
    fp32_t a_word, b_word, word;

    // binary32 word of an unpacked operand
    function automatic fp32_t repack(input logic s, input iexp_t e, input mant_t m);
        fp32_t w;
        if (e >= iexp_t'(1 - `FP_BIAS)) begin
            w = {s, `FP_EXP_W'(e + iexp_t'(`FP_BIAS)), m[`MANT_W-3:3]};
        end else begin
            w = {s, `FP_EXP_W'(0), `FP_FRAC_W'(m[`MANT_W-2:3] >> (1 - `FP_BIAS - e))};
        end
        return w;
    endfunction

    always_comb begin
        b_eff   = b_sign ^ (unp_op == OP_SUB);
        eff_sub = a_sign ^ b_eff;
        a_big   = b_zero | (~a_zero & ((a_exp > b_exp)
                | ((a_exp == b_exp) & (a_mant >= b_mant))));
        mag_eq  = (a_exp == b_exp) & (a_mant == b_mant);

        // align the smaller magnitude, then add or subtract
        big_exp    = a_big ? a_exp : b_exp;
        big_mant   = a_big ? a_mant : b_mant;
        small_mant = a_big ? b_mant : a_mant;
        diff       = big_exp - (a_big ? b_exp : a_exp);
        small_sh   = shr_sticky(small_mant, diff);
        sum        = eff_sub ? big_mant - small_sh : big_mant + small_sh;
        sum[0]     = sum[0] | small_sh[0];
        res_sign   = a_big ? a_sign : b_eff;
        if (sum == '0) begin
            res_sign = eff_sub ? (unp_rm == RM_RDN) : a_sign;  // exact zero
        end

        // ordering for compares and min/max
        both_zero = a_zero & b_zero;
        any_nan   = a_nan | b_nan;
        eq        = both_zero | ((a_sign == b_sign) & mag_eq);
        if (a_sign != b_sign) begin
            lt = a_sign & ~both_zero;
        end else begin
            lt = a_sign ? (a_big & ~mag_eq) : ~a_big;
        end
        pick_a = lt | (eq & a_sign);                 // -0 below +0

        a_word = repack(a_sign, a_exp, a_mant);
        b_word = repack(b_sign, b_exp, b_mant);
        byp    = 1'b1;
        nv_d   = snan;
        word   = `CANON_NAN;
        case (unp_op)
            OP_ADD, OP_SUB: begin
                byp = any_nan | a_inf | b_inf;
                if (a_inf & b_inf & eff_sub) begin
                    nv_d = 1'b1;                     // inf - inf
                end else if (!any_nan) begin
                    word = {a_inf ? a_sign : b_eff, `FP_EXP_W'(`FP_EXP_MAX), `FP_FRAC_W'(0)};
                end
            end
            OP_EQ: word = fp32_t'(~any_nan & eq);
            OP_LT: begin
                word = fp32_t'(~any_nan & lt);
                nv_d = any_nan;
            end
            OP_LE: begin
                word = fp32_t'(~any_nan & (lt | eq));
                nv_d = any_nan;
            end
            OP_MIN, OP_MAX: begin
                if (a_nan & b_nan) begin
                    word = `CANON_NAN;
                end else if (a_nan | b_nan) begin
                    word = a_nan ? b_word : a_word;  // the non-nan operand
                end else begin
                    word = (pick_a ^ (unp_op == OP_MAX)) ? a_word : b_word;
                end
            end
            OP_SGNJ: begin
                word = {b_sign, a_word[`FP_EXP_W+`FP_FRAC_W-1:0]};
                nv_d = 1'b0;
            end
            OP_SGNJN: begin
                word = {~b_sign, a_word[`FP_EXP_W+`FP_FRAC_W-1:0]};
                nv_d = 1'b0;
            end
            OP_SGNJX: begin
                word = {a_sign ^ b_sign, a_word[`FP_EXP_W+`FP_FRAC_W-1:0]};
                nv_d = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= unp_valid;
        end
    end

    always_ff @(posedge clk) begin
        rm_q        <= unp_rm;
        sign        <= res_sign;
        exp         <= big_exp;
        mant        <= sum;
        bypass      <= byp;
        bypass_word <= word;
        nv          <= nv_d;
    end

endmodule

// ==== fp_format_pkg.sv ====
`include "fpu_macros.svh"

package fp_format_pkg;

    typedef logic [`FP_EXP_W+`FP_FRAC_W:0] fp32_t;     // packed binary32 word
    typedef logic signed [`IEXP_W-1:0]     iexp_t;     // unbiased exponent
    typedef logic [`MANT_W-1:0]            mant_t;     // 2 integer bits, 23 fraction, grs

    // right shift, every bit shifted out is or-ed into bit 0
    function automatic mant_t shr_sticky(input mant_t m, input iexp_t sh);
        mant_t r;
        if (sh >= iexp_t'(`MANT_W)) begin
            r = mant_t'(|m);
        end else begin
            r = m >> sh;
            r[0] = r[0] | (|(m & ((mant_t'(1) << sh) - mant_t'(1))));
        end
        return r;
    endfunction

endpackage

// ==== fp_normalize.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_normalize (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    add_valid,
    input  fpu_op_pkg::round_mode_t add_rm,
    input  logic                    add_sign,
    input  fp_format_pkg::iexp_t    add_exp,
    input  fp_format_pkg::mant_t    add_mant,
    input  logic                    add_bypass,
    input  fp_format_pkg::fp32_t    add_word,
    input  logic                    add_nv,
    output logic                    valid,
    output fpu_op_pkg::round_mode_t rm_q,
    output logic                    sign,
    output fp_format_pkg::iexp_t    exp,
    output fp_format_pkg::mant_t    mant,
    output logic                    bypass,
    output fp_format_pkg::fp32_t    bypass_word,
    output logic                    nv
);
    import fp_format_pkg::*;

    int    lead;        // position of the leading one
    iexp_t n_exp;
    mant_t n_mant;

    always_comb begin
        lead = 0;
        for (int i = 0; i < `MANT_W; i++) begin
            if (add_mant[i]) lead = i;
        end
        if (add_mant == '0) begin
            n_mant = '0;
            n_exp  = -iexp_t'(`FP_BIAS);                    // packs as a zero
        end else if (add_mant[`MANT_W-1]) begin
            n_mant = shr_sticky(add_mant, iexp_t'(1));      // carry out of the add
            n_exp  = add_exp + iexp_t'(1);
        end else begin
            // cancellation, hidden bit goes back to MANT_W-2
            n_mant = add_mant << (`MANT_W - 2 - lead);
            n_exp  = add_exp - iexp_t'(`MANT_W - 2 - lead);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= add_valid;
        end
    end

    always_ff @(posedge clk) begin
        rm_q        <= add_rm;
        sign        <= add_sign;
        exp         <= n_exp;
        mant        <= n_mant;
        bypass      <= add_bypass;
        bypass_word <= add_word;
        nv          <= add_nv;
    end

endmodule

// ==== fp_round_pack.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_round_pack (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    norm_valid,
    input  fpu_op_pkg::round_mode_t norm_rm,
    input  logic                    norm_sign,
    input  fp_format_pkg::iexp_t    norm_exp,
    input  fp_format_pkg::mant_t    norm_mant,
    input  logic                    norm_bypass,
    input  fp_format_pkg::fp32_t    norm_word,
    input  logic                    norm_nv,
    output logic                    out_valid,
    output fp_format_pkg::fp32_t    result,
    output fpu_op_pkg::fflags_t     flags
);
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    iexp_t                 e;
    mant_t                 m;
    logic [`FP_FRAC_W+1:0] rnd;         // carry, hidden, fraction
    logic [`FP_EXP_W-1:0]  bexp;
    logic                  inexact, inc, ovf, to_inf;
    fp32_t                 word;

    always_comb begin
        e = norm_exp;
        m = norm_mant;
        if (norm_exp < iexp_t'(1 - `FP_BIAS)) begin
            m = shr_sticky(norm_mant, iexp_t'(1 - `FP_BIAS) - norm_exp);  // subnormal
            e = iexp_t'(1 - `FP_BIAS);
        end
        inexact = |m[2:0];
        case (norm_rm)
            RM_RNE:  inc = m[2] & (|m[1:0] | m[3]);
            RM_RDN:  inc = norm_sign & inexact;
            RM_RUP:  inc = ~norm_sign & inexact;
            RM_RMM:  inc = m[2];
            default: inc = 1'b0;                        // rtz
        endcase
        rnd = {1'b0, m[`MANT_W-2:3]} + (`FP_FRAC_W+2)'(inc);
        if (rnd[`FP_FRAC_W+1]) begin
            rnd = rnd >> 1;                             // rounded up to next binade
            e   = e + iexp_t'(1);
        end
        // a subnormal that rounds up into the hidden bit becomes normal here
        bexp = rnd[`FP_FRAC_W] ? `FP_EXP_W'(e + iexp_t'(`FP_BIAS)) : '0;
        ovf  = e > iexp_t'(`FP_BIAS);
        case (norm_rm)
            RM_RTZ:  to_inf = 1'b0;
            RM_RDN:  to_inf = norm_sign;
            RM_RUP:  to_inf = ~norm_sign;
            default: to_inf = 1'b1;
        endcase
        word = {norm_sign, bexp, rnd[`FP_FRAC_W-1:0]};
        if (ovf && to_inf) begin
            word = {norm_sign, `FP_EXP_W'(`FP_EXP_MAX), `FP_FRAC_W'(0)};
        end else if (ovf) begin
            word = {norm_sign, `FP_EXP_W'(`FP_EXP_MAX - 1), {`FP_FRAC_W{1'b1}}};  // max finite
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= norm_valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= norm_bypass ? norm_word : word;
        flags  <= {norm_nv, ~norm_bypass & (inexact | ovf)};
    end

endmodule

// ==== fp_unpack.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_unpack (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  fpu_op_pkg::fpu_op_t     op,
    input  fpu_op_pkg::round_mode_t rm,
    input  fp_format_pkg::fp32_t    a,
    input  fp_format_pkg::fp32_t    b,
    output logic                    valid,
    output fpu_op_pkg::fpu_op_t     op_q,
    output fpu_op_pkg::round_mode_t rm_q,
    output logic                    a_sign,
    output logic                    b_sign,
    output fp_format_pkg::iexp_t    a_exp,
    output fp_format_pkg::iexp_t    b_exp,
    output fp_format_pkg::mant_t    a_mant,
    output fp_format_pkg::mant_t    b_mant,
    output logic                    a_nan,
    output logic                    b_nan,
    output logic                    a_inf,
    output logic                    b_inf,
    output logic                    a_zero,
    output logic                    b_zero,
    output logic                    snan
);
    import fp_format_pkg::*;

    iexp_t a_e, b_e;
    mant_t a_m, b_m;
    logic  a_top, b_top;    // exponent all ones
    logic  a_fz, b_fz;      // fraction zero

    // exponent and mantissa of one operand, subnormals brought to hidden position
    function automatic void split(input fp32_t w, output iexp_t e, output mant_t m);
        logic [`FP_EXP_W-1:0]  be;
        logic [`FP_FRAC_W-1:0] fr;
        int                    lead;
        be   = w[`FP_FRAC_W +: `FP_EXP_W];
        fr   = w[`FP_FRAC_W-1:0];
        lead = 0;
        for (int i = 0; i < `FP_FRAC_W; i++) begin
            if (fr[i]) lead = i;
        end
        m = {2'b01, fr, 3'b000};
        e = iexp_t'(be) - iexp_t'(`FP_BIAS);
        if (be == '0) begin
            if (fr == '0) begin
                m = '0;
                e = -iexp_t'(`FP_BIAS);   // repacks to a zero exponent field
            end else begin
                m = mant_t'({fr, 3'b000}) << (`FP_FRAC_W - lead);
                e = iexp_t'(1 - `FP_BIAS - `FP_FRAC_W + lead);
            end
        end
    endfunction

    always_comb begin
        split(a, a_e, a_m);
        split(b, b_e, b_m);
    end

    assign a_top = a[`FP_FRAC_W +: `FP_EXP_W] == `FP_EXP_W'(`FP_EXP_MAX);
    assign b_top = b[`FP_FRAC_W +: `FP_EXP_W] == `FP_EXP_W'(`FP_EXP_MAX);
    assign a_fz  = a[`FP_FRAC_W-1:0] == '0;
    assign b_fz  = b[`FP_FRAC_W-1:0] == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        op_q   <= op;
        rm_q   <= rm;
        a_sign <= a[`FP_EXP_W+`FP_FRAC_W];
        b_sign <= b[`FP_EXP_W+`FP_FRAC_W];
        a_exp  <= a_e;
        b_exp  <= b_e;
        a_mant <= a_m;
        b_mant <= b_m;
        a_nan  <= a_top & ~a_fz;
        b_nan  <= b_top & ~b_fz;
        a_inf  <= a_top & a_fz;
        b_inf  <= b_top & b_fz;
        a_zero <= a[`FP_EXP_W+`FP_FRAC_W-1:0] == '0;
        b_zero <= b[`FP_EXP_W+`FP_FRAC_W-1:0] == '0;
        snan   <= (a_top & ~a_fz & ~a[`FP_FRAC_W-1])       // quiet bit clear
                | (b_top & ~b_fz & ~b[`FP_FRAC_W-1]);
    end

endmodule

// ==== fpu_macros.svh ====
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// binary32 format
`define FP_EXP_W    8
`define FP_FRAC_W   23
`define FP_BIAS     127
`define FP_EXP_MAX  255         // all ones, inf and nan

// internal datapath
`define MANT_W      28          // carry, hidden, fraction, guard, round, sticky
`define IEXP_W      10          // signed, wide enough for underflow and overflow

`define FPU_LATENCY 4           // in_valid to out_valid
`define CANON_NAN   32'h7fc00000

`endif

// ==== fpu_op_pkg.sv ====
package fpu_op_pkg;

    // operations handled by the pipeline
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_MIN   = 4'd2,
        OP_MAX   = 4'd3,
        OP_EQ    = 4'd4,
        OP_LT    = 4'd5,
        OP_LE    = 4'd6,
        OP_SGNJ  = 4'd7,
        OP_SGNJN = 4'd8,
        OP_SGNJX = 4'd9
    } fpu_op_t;

    // encoding follows the risc-v rm field
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } round_mode_t;

    typedef logic [1:0] fflags_t;   // [1] nv, [0] nx

endpackage

// ==== fpu_pipe.sv ====
`timescale 1ns/1ps

module fpu_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  fpu_op_pkg::fpu_op_t     op,
    input  fpu_op_pkg::round_mode_t rm,
    input  fp_format_pkg::fp32_t    a,
    input  fp_format_pkg::fp32_t    b,
    output logic                    out_valid,
    output fp_format_pkg::fp32_t    result,
    output fpu_op_pkg::fflags_t     flags
);
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    // unpack to align-add
    logic        unp_valid;
    fpu_op_t     unp_op;
    round_mode_t unp_rm;
    logic        a_sign, b_sign, a_nan, b_nan, a_inf, b_inf, a_zero, b_zero, snan;
    iexp_t       a_exp, b_exp;
    mant_t       a_mant, b_mant;

    // align-add to normalize
    logic        add_valid, add_sign, add_bypass, add_nv;
    round_mode_t add_rm;
    iexp_t       add_exp;
    mant_t       add_mant;
    fp32_t       add_word;

    // normalize to round-pack
    logic        norm_valid, norm_sign, norm_bypass, norm_nv;
    round_mode_t norm_rm;
    iexp_t       norm_exp;
    mant_t       norm_mant;
    fp32_t       norm_word;

    fp_unpack u_unpack (
        .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .rm(rm), .a(a), .b(b),
        .valid(unp_valid), .op_q(unp_op), .rm_q(unp_rm),
        .a_sign(a_sign), .b_sign(b_sign), .a_exp(a_exp), .b_exp(b_exp),
        .a_mant(a_mant), .b_mant(b_mant), .a_nan(a_nan), .b_nan(b_nan),
        .a_inf(a_inf), .b_inf(b_inf), .a_zero(a_zero), .b_zero(b_zero), .snan(snan)
    );

    fp_align_add u_align_add (
        .clk(clk), .rst(rst), .unp_valid(unp_valid), .unp_op(unp_op), .unp_rm(unp_rm),
        .a_sign(a_sign), .b_sign(b_sign), .a_exp(a_exp), .b_exp(b_exp),
        .a_mant(a_mant), .b_mant(b_mant), .a_nan(a_nan), .b_nan(b_nan),
        .a_inf(a_inf), .b_inf(b_inf), .a_zero(a_zero), .b_zero(b_zero), .snan(snan),
        .valid(add_valid), .rm_q(add_rm), .sign(add_sign), .exp(add_exp), .mant(add_mant),
        .bypass(add_bypass), .bypass_word(add_word), .nv(add_nv)
    );

    fp_normalize u_normalize (
        .clk(clk), .rst(rst), .add_valid(add_valid), .add_rm(add_rm),
        .add_sign(add_sign), .add_exp(add_exp), .add_mant(add_mant),
        .add_bypass(add_bypass), .add_word(add_word), .add_nv(add_nv),
        .valid(norm_valid), .rm_q(norm_rm), .sign(norm_sign), .exp(norm_exp),
        .mant(norm_mant), .bypass(norm_bypass), .bypass_word(norm_word), .nv(norm_nv)
    );

    fp_round_pack u_round_pack (
        .clk(clk), .rst(rst), .norm_valid(norm_valid), .norm_rm(norm_rm),
        .norm_sign(norm_sign), .norm_exp(norm_exp), .norm_mant(norm_mant),
        .norm_bypass(norm_bypass), .norm_word(norm_word), .norm_nv(norm_nv),
        .out_valid(out_valid), .result(result), .flags(flags)
    );

endmodule

// ==== fpu_tb.sv ====
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_tb;
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    localparam int MAX_GROUPS = 8;
    localparam int CLK_NS     = 40;

    logic        clk;
    logic        rst;
    logic        in_valid;
    fpu_op_t     op;
    round_mode_t rm;
    fp32_t       a;
    fp32_t       b;
    logic        out_valid;
    fp32_t       result;
    fflags_t     flags;

    // vectors as read from the file
    int          v_group[$];
    logic [3:0]  v_op[$];
    logic [2:0]  v_rm[$];
    logic [31:0] v_a[$];
    logic [31:0] v_b[$];
    logic [31:0] v_res[$];
    logic [31:0] v_flags[$];

    // operations in flight, oldest first
    int          q_group[$];
    int          q_index[$];
    int          q_due[$];
    logic [31:0] q_res[$];
    logic [31:0] q_flags[$];

    int grp_total[MAX_GROUPS];
    int grp_seen[MAX_GROUPS];
    int grp_errs[MAX_GROUPS];   // group 0 is the reset test
    int cyc         = 0;        // rising edges seen so far
    int errors      = 0;
    int checks      = 0;
    int check_group = 0;
    int tests_pass  = 0;
    int tests_fail  = 0;
    int seed        = 95;
    bit loaded      = 1'b0;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) u_clk (.clk(clk), .rst(rst));

    fpu_pipe dut0 (
        .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .rm(rm), .a(a), .b(b),
        .out_valid(out_valid), .result(result), .flags(flags)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            grp_errs[check_group]++;
        end
    endtask

    function automatic string group_name(input int g);
        case (g)
            1:       return "add/sub rounding";
            2:       return "specials";
            3:       return "range edges";
            4:       return "compare, min/max, sign injection";
            5:       return "back-to-back timing";
            default: return "misc";
        endcase
    endfunction

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: pass", name);
            tests_pass++;
        end else begin
            $display("test %s: FAIL with %0d errors", name, errs);
            tests_fail++;
        end
    endtask

    // oldest entry leaves the queue, either checked or reported missing
    task automatic take_result(input bit arrived);
        int          g;
        int          idx;
        int          due;
        logic [31:0] exp_res;
        logic [31:0] exp_flags;
        g         = q_group.pop_front();
        idx       = q_index.pop_front();
        due       = q_due.pop_front();
        exp_res   = q_res.pop_front();
        exp_flags = q_flags.pop_front();
        check_group = g;
        if (arrived) begin
            check_value(result, exp_res, $sformatf("vector %0d result", idx));
            check_value({30'b0, flags}, exp_flags, $sformatf("vector %0d flags", idx));
            check_value(cyc, due, $sformatf("vector %0d arrival cycle", idx));
        end else begin
            $display("ERROR at %0t ns: result of vector %0d never arrived, due in cycle %0d",
                     $time, idx, due);
            errors++;
            grp_errs[g]++;
        end
        grp_seen[g]++;
        if (grp_seen[g] == grp_total[g]) begin
            report_test($sformatf("%0d %s", g, group_name(g)), grp_errs[g]);
        end
    endtask

    // outputs change on the rising edge, so they are sampled on the falling one
    always @(negedge clk) begin
        if (rst) begin
            check_group = 0;
            check_value({31'b0, out_valid}, 32'd0, "out_valid during reset");
        end else if (out_valid) begin
            if (q_due.size() == 0) begin
                $display("ERROR at %0t ns: result %h arrived with no operation in flight",
                         $time, result);
                errors++;
            end else begin
                take_result(1'b1);
            end
        end else if (q_due.size() != 0 && q_due[0] <= cyc) begin
            take_result(1'b0);
        end
    end

    task automatic read_vectors(output bit ok);
        int          fd;
        int          rc;
        int          g;
        int          o;
        int          r;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] vr;
        logic [31:0] vf;
        string       line;
        ok = 1'b0;
        fd = $fopen("fpu_vectors.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 0 && line[0] != 8'h23) begin   // skip '#' lines
                rc = $sscanf(line, "%d %d %d %h %h %h %h", g, o, r, va, vb, vr, vf);
                if (rc == 7 && g > 0 && g < MAX_GROUPS) begin
                    v_group.push_back(g);
                    v_op.push_back(o[3:0]);
                    v_rm.push_back(r[2:0]);
                    v_a.push_back(va);
                    v_b.push_back(vb);
                    v_res.push_back(vr);
                    v_flags.push_back(vf);
                    grp_total[g]++;
                end
            end
        end
        $fclose(fd);
        ok = (v_op.size() > 0);
    endtask

    task automatic issue(input int i);
        op       = fpu_op_t'(v_op[i]);
        rm       = round_mode_t'(v_rm[i]);
        a        = v_a[i];
        b        = v_b[i];
        in_valid = 1'b1;
        q_group.push_back(v_group[i]);
        q_index.push_back(i);
        q_due.push_back(cyc + `FPU_LATENCY);       // cyc when the monitor sees out_valid
        q_res.push_back(v_res[i]);
        q_flags.push_back(v_flags[i]);
    endtask

    task automatic run_all();
        int idle;
        int waited;
        @(negedge clk);
        while (rst) @(negedge clk);
        repeat (2) @(negedge clk);                 // out_valid must stay quiet
        report_test("reset", grp_errs[0]);
        for (int i = 0; i < v_op.size(); i++) begin
            issue(i);
            @(negedge clk);
            in_valid = 1'b0;
            idle = (v_group[i] == 5) ? 0 : int'($unsigned($random(seed)) % 3);
            repeat (idle) @(negedge clk);
        end
        waited = 0;
        while (q_due.size() != 0 && waited < 2 * `FPU_LATENCY + 4) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (q_due.size() != 0) begin
            $display("ERROR: %0d results still outstanding at the end of the run",
                     q_due.size());
            errors++;
        end
        repeat (2) @(negedge clk);                 // catch stray results
    endtask

    initial begin : main
        bit ok;
        in_valid = 1'b0;
        op       = OP_ADD;
        rm       = RM_RNE;
        a        = '0;
        b        = '0;
        read_vectors(ok);
        loaded = 1'b1;
        if (!ok) begin
            $display("ERROR: no usable vectors could be read from fpu_vectors.txt");
            errors++;
        end else begin
            run_all();
        end
        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_pass, tests_fail, checks, errors);
        if (errors == 0 && tests_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(v_op.size() * 3 + `FPU_LATENCY + 20) * CLK_NS;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== fpu_vectors.txt ====
# group op rm a b result flags
# op and rm in decimal, words in hex, flags hex with bit 1 nv and bit 0 nx
1 0 0 3f800000 40000000 40400000 0
1 1 0 3f800000 33800000 3f7fffff 0
1 0 0 3f800000 33800000 3f800000 1
1 0 0 3f800000 33c00000 3f800001 1
1 0 1 3dcccccd 3e4ccccd 3e999999 1
1 0 2 bf800000 b3800000 bf800001 1
1 0 3 3f800000 30800000 3f800001 1
1 0 4 3f800000 33800000 3f800001 1
1 0 0 3dcccccd 3e4ccccd 3e99999a 1
2 1 0 7f800000 7f800000 7fc00000 2
2 0 0 7fc12345 3f800000 7fc00000 0
2 0 0 3f800000 7f800001 7fc00000 2
2 1 0 3f800000 7f800000 ff800000 0
2 0 0 7f800000 3f800000 7f800000 0
3 1 0 00800000 00000001 007fffff 0
3 0 0 007fffff 00000001 00800000 0
3 0 0 80000003 00000001 80000002 0
3 1 0 3f800000 3f800000 00000000 0
3 1 2 3f800000 3f800000 80000000 0
3 0 0 7f7fffff 7f7fffff 7f800000 1
3 0 1 7f7fffff 7f7fffff 7f7fffff 1
3 0 3 ff7fffff ff7fffff ff7fffff 1
3 0 0 7f7fffff 73000000 7f800000 1
4 4 0 00000000 80000000 00000001 0
4 4 0 7f800001 3f800000 00000000 2
4 5 0 c0000000 bf800000 00000001 0
4 5 0 7fc00000 3f800000 00000000 2
4 6 0 3f800000 3f800000 00000001 0
4 2 0 00000000 80000000 80000000 0
4 3 0 80000000 00000000 00000000 0
4 2 0 7fc00000 3f800000 3f800000 0
4 2 0 7f800001 3f800000 3f800000 2
4 3 0 7fc00000 7fc00000 7fc00000 0
4 7 0 7f800001 80000000 ff800001 0
4 8 0 3f800000 bf800000 3f800000 0
4 9 0 40400000 c0000000 c0400000 0
5 0 0 3f800000 40000000 40400000 0
5 5 0 3f800000 40000000 00000001 0
5 3 0 bf800000 3f800000 3f800000 0
5 9 0 bf800000 3f800000 bf800000 0
5 1 0 7f800000 7f800000 7fc00000 2

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);   // held over RESET_CYCLES rising edges
        @(negedge clk);
        rst = 1'b0;                             // released away from the active edge
    end

endmodule
